// File: Makefile
# Verilator build and run of the fetch stage testbench

VERILATOR       ?= verilator
TOP             ?= stage_fetch_tb
FILELIST        ?= stage_fetch.f
BUILD_DIR       ?= build
VERILATOR_FLAGS ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VERILATOR_FLAGS"

test:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: design/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // One line holds four instruction words
    localparam int LINE_BITS  = 128;
    localparam int LINE_COUNT = 16;

    // Exception codes, shared by the fetch output and the ROB input
    localparam logic [2:0] EXC_NONE      = 3'd0;
    localparam logic [2:0] EXC_ITLB_MISS = 3'd3;

    // Privileged register indices
    localparam logic [2:0] PRIV_HANDLER    = 3'd0;
    localparam logic [2:0] PRIV_FAULT_PC   = 3'd1;
    localparam logic [2:0] PRIV_FAULT_ADDR = 3'd2;
    localparam logic [2:0] PRIV_CAUSE      = 3'd3;
    localparam logic [2:0] PRIV_STATUS     = 3'd4;

    // Fetch address, raw or split for the direct-mapped cache
    // 24-bit tag, 4-bit line index, 4-bit byte offset
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [23:0] tag;
            logic [3:0]  index;
            logic [3:0]  offset;
        } fields;
    } fetch_addr_u;

endpackage

`default_nettype wire

// File: design/icache.sv
`timescale 1ns/1ps
`default_nettype none

module icache (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            tlb_hit,
    input  logic [31:0]                     addr,
    input  logic [fetch_pkg::LINE_BITS-1:0] mem_read_data,
    input  logic                            mem_ready,
    output logic [31:0]                     read_data,
    output logic                            busy,
    output logic                            mem_read_en,
    output logic [31:0]                     mem_addr
);

    logic [fetch_pkg::LINE_COUNT-1:0] line_valid;
    logic [23:0]                      line_tag  [fetch_pkg::LINE_COUNT];
    logic [fetch_pkg::LINE_BITS-1:0]  line_data [fetch_pkg::LINE_COUNT];

    fetch_pkg::fetch_addr_u           lookup;
    fetch_pkg::fetch_addr_u           fill;
    logic                             fill_pending;

    logic [fetch_pkg::LINE_BITS-1:0]  hit_line;
    logic [1:0]                       word_sel;
    logic                             tag_match;
    logic                             miss;

    assign lookup.raw = addr;

    // Direct-mapped probe
    assign hit_line  = line_data[lookup.fields.index];
    assign tag_match = line_valid[lookup.fields.index]
                    && (line_tag[lookup.fields.index] == lookup.fields.tag);

    // No access at all when translation failed
    assign miss = tlb_hit && !tag_match;

    // Word k of the line sits at bits 32k and up
    assign word_sel  = lookup.fields.offset[3:2];
    assign read_data = tag_match ? hit_line[word_sel*32 +: 32] : 32'h0;

    // Busy through the mem_ready cycle, even if fetch was redirected
    assign busy = miss || fill_pending;

    assign mem_read_en = fill_pending;
    assign mem_addr    = fill.raw;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            fill_pending <= 1'b0;
            line_valid   <= '0;
        end else if (fill_pending) begin
            if (mem_ready) begin
                fill_pending                  <= 1'b0;
                line_valid[fill.fields.index] <= 1'b1;
            end
        end else if (miss) begin
            // Request goes out the cycle after detection
            fill_pending <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        // Line address, held while the request is open
        if (!fill_pending && miss) begin
            fill.fields.tag    <= lookup.fields.tag;
            fill.fields.index  <= lookup.fields.index;
            fill.fields.offset <= 4'h0;
        end
        if (fill_pending && mem_ready) begin
            line_tag[fill.fields.index]  <= fill.fields.tag;
            line_data[fill.fields.index] <= mem_read_data;
        end
    end

endmodule

`default_nettype wire

// File: design/itlb.sv
`timescale 1ns/1ps
`default_nettype none

module itlb #(
    parameter int TLB_ENTRIES = 4
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        supervisor_mode,
    input  logic [31:0] virtual_address,
    input  logic        write_en,
    input  logic [31:0] write_vaddr,
    input  logic [31:0] write_paddr,
    output logic [31:0] physical_address,
    output logic        tlb_hit
);

    localparam int PTR_BITS = (TLB_ENTRIES > 1) ? $clog2(TLB_ENTRIES) : 1;

    logic [TLB_ENTRIES-1:0] entry_valid;
    logic [19:0]            entry_vpn [TLB_ENTRIES];
    logic [19:0]            entry_ppn [TLB_ENTRIES];
    logic [PTR_BITS-1:0]    victim_ptr;

    logic                   lookup_hit;
    logic [19:0]            lookup_ppn;
    logic                   refill_hit;
    logic [PTR_BITS-1:0]    refill_idx;
    logic [PTR_BITS-1:0]    write_slot;

    // Fully associative lookup on the 20-bit page number
    always_comb begin
        lookup_hit = 1'b0;
        lookup_ppn = 20'h0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (entry_valid[i] && (entry_vpn[i] == virtual_address[31:12])) begin
                lookup_hit = 1'b1;
                lookup_ppn = entry_ppn[i];
            end
        end
    end

    // Supervisor fetches map identity
    assign tlb_hit = supervisor_mode || lookup_hit;
    assign physical_address = supervisor_mode ? virtual_address
                                              : {lookup_ppn, virtual_address[11:0]};

    // A refill of a page already held rewrites that entry
    always_comb begin
        refill_hit = 1'b0;
        refill_idx = '0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (entry_valid[i] && (entry_vpn[i] == write_vaddr[31:12])) begin
                refill_hit = 1'b1;
                refill_idx = PTR_BITS'(i);
            end
        end
    end

    assign write_slot = refill_hit ? refill_idx : victim_ptr;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            entry_valid <= '0;
            victim_ptr  <= '0;
        end else if (write_en) begin
            entry_valid[write_slot] <= 1'b1;
            // Round-robin replacement on new pages only
            if (!refill_hit) begin
                if (victim_ptr == PTR_BITS'(TLB_ENTRIES - 1)) begin
                    victim_ptr <= '0;
                end else begin
                    victim_ptr <= victim_ptr + PTR_BITS'(1);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (write_en) begin
            entry_vpn[write_slot] <= write_vaddr[31:12];
            entry_ppn[write_slot] <= write_paddr[31:12];
        end
    end

endmodule

`default_nettype wire

// File: design/privileged_regs.sv
`timescale 1ns/1ps
`default_nettype none

module privileged_regs (
    input  logic        clk,
    input  logic        reset,
    input  logic [2:0]  priv_idx,
    input  logic        write_en,
    input  logic [31:0] write_data,
    input  logic [2:0]  exception_vector,
    input  logic [31:0] fault_pc,
    input  logic [31:0] fault_addr,
    output logic [31:0] new_address,
    output logic        overwrite_pc,
    output logic        supervisor_mode
);

    // Eight slots addressed by the 3-bit index, upper ones are scratch
    logic [31:0] priv_file [0:7];
    logic        exception_taken;
    logic [31:0] status_now;

    assign exception_taken = (exception_vector != fetch_pkg::EXC_NONE);
    assign status_now      = priv_file[fetch_pkg::PRIV_STATUS];

    // Redirect in the same cycle as the exception
    assign overwrite_pc    = exception_taken;
    assign new_address     = priv_file[fetch_pkg::PRIV_HANDLER];

    // Status bit 0 is the current mode
    assign supervisor_mode = status_now[0];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 8; i++) begin
                priv_file[i] <= 32'h0;
            end
            // Come out of reset in supervisor mode
            priv_file[fetch_pkg::PRIV_STATUS] <= 32'h1;
        end else if (exception_taken) begin
            priv_file[fetch_pkg::PRIV_FAULT_PC]   <= fault_pc;
            priv_file[fetch_pkg::PRIV_FAULT_ADDR] <= fault_addr;
            priv_file[fetch_pkg::PRIV_CAUSE]      <= {29'b0, exception_vector};
            // Bit 1 keeps the mode the trap came from
            priv_file[fetch_pkg::PRIV_STATUS] <= {status_now[31:2], status_now[0], 1'b1};
        end else if (write_en) begin
            // Clearing status bit 0 drops to user mode
            priv_file[priv_idx] <= write_data;
        end
    end

endmodule

`default_nettype wire

// File: design/stage_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module stage_fetch #(
    parameter logic [31:0] INIT_ADDR   = 32'h1000,
    parameter int          TLB_ENTRIES = 4
) (
    input  logic                            clk,
    input  logic                            reset,

    input  logic                            branch_taken,
    input  logic [31:0]                     new_pc,
    input  logic                            pc_write_disable,
    input  logic                            d_cache_stall,

    input  logic [fetch_pkg::LINE_BITS-1:0] mem_read_data,
    input  logic                            mem_ready,

    input  logic [2:0]                      rob_exception_vector,
    input  logic [31:0]                     rob_fault_pc,
    input  logic [31:0]                     rob_fault_addr,

    input  logic                            priv_write_en,
    input  logic [2:0]                      priv_idx,
    input  logic [31:0]                     priv_write_data,

    input  logic                            itlb_write_en,
    input  logic [31:0]                     itlb_write_vaddr,
    input  logic [31:0]                     itlb_write_paddr,

    output logic [31:0]                     pc_out,
    output logic [31:0]                     instruction,
    output logic                            stall,
    output logic                            mem_read_en,
    output logic [31:0]                     mem_addr,
    output logic [2:0]                      fetch_exception
);

    logic [31:0] pc;
    logic [31:0] next_pc;
    logic        pc_hold;

    logic        supervisor_mode;
    logic        overwrite_pc;
    logic [31:0] handler_addr;
    logic [31:0] physical_address;
    logic        tlb_hit;
    logic [31:0] cache_word;

    assign pc_out  = pc;
    assign pc_hold = pc_write_disable || d_cache_stall;

    // Branch first, then trap redirect, then sequential
    always_comb begin
        if (branch_taken) begin
            next_pc = new_pc;
        end else if (overwrite_pc) begin
            next_pc = handler_addr;
        end else if (!stall) begin
            next_pc = pc + 32'd4;
        end else begin
            next_pc = pc;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= INIT_ADDR;
        end else if (!pc_hold) begin
            pc <= next_pc;
        end
    end

    // Untranslated fetch gives no instruction
    assign instruction     = tlb_hit ? cache_word : 32'h0;
    assign fetch_exception = tlb_hit ? fetch_pkg::EXC_NONE : fetch_pkg::EXC_ITLB_MISS;

    privileged_regs u_privileged_regs (
        .clk              (clk),
        .reset            (reset),
        .priv_idx         (priv_idx),
        .write_en         (priv_write_en),
        .write_data       (priv_write_data),
        .exception_vector (rob_exception_vector),
        .fault_pc         (rob_fault_pc),
        .fault_addr       (rob_fault_addr),
        .new_address      (handler_addr),
        .overwrite_pc     (overwrite_pc),
        .supervisor_mode  (supervisor_mode)
    );

    itlb #(
        .TLB_ENTRIES (TLB_ENTRIES)
    ) u_itlb (
        .clk              (clk),
        .reset            (reset),
        .supervisor_mode  (supervisor_mode),
        .virtual_address  (pc),
        .write_en         (itlb_write_en),
        .write_vaddr      (itlb_write_vaddr),
        .write_paddr      (itlb_write_paddr),
        .physical_address (physical_address),
        .tlb_hit          (tlb_hit)
    );

    icache u_icache (
        .clk           (clk),
        .reset         (reset),
        .tlb_hit       (tlb_hit),
        .addr          (physical_address),
        .mem_read_data (mem_read_data),
        .mem_ready     (mem_ready),
        .read_data     (cache_word),
        .busy          (stall),
        .mem_read_en   (mem_read_en),
        .mem_addr      (mem_addr)
    );

endmodule

`default_nettype wire

// File: stage_fetch.f
design/fetch_pkg.sv
design/privileged_regs.sv
design/itlb.sv
design/icache.sv
design/stage_fetch.sv
tests/stage_fetch_properties.sv
tests/stage_fetch_tb.sv

// File: tests/stage_fetch_properties.sv
`timescale 1ns/1ps
`default_nettype none

module stage_fetch_properties (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] pc_out,
    input  logic        pc_write_disable,
    input  logic        d_cache_stall,
    input  logic        stall,
    input  logic        mem_read_en,
    input  logic        mem_ready,
    input  logic [31:0] mem_addr,
    input  logic [31:0] instruction,
    input  logic [2:0]  fetch_exception
);

    // Line address held for the whole request
    mem_addr_held: assert property (@(posedge clk) disable iff (reset)
        (mem_read_en && !mem_ready) |=> (mem_read_en && $stable(mem_addr)))
        else $error("mem_addr moved while a line request was open");

    // A miss keeps fetch stalled until memory answers
    stall_until_ready: assert property (@(posedge clk) disable iff (reset)
        (stall && !mem_ready) |=> stall)
        else $error("stall fell before mem_ready");

    pc_held: assert property (@(posedge clk) disable iff (reset)
        (pc_write_disable || d_cache_stall) |=> $stable(pc_out))
        else $error("PC moved while held by the back end");

    // Translation fault gives no instruction word
    no_word_on_fault: assert property (@(posedge clk) disable iff (reset)
        (fetch_exception != fetch_pkg::EXC_NONE) |-> (instruction == 32'h0))
        else $error("instruction driven together with a fetch exception");

    request_closes: assert property (@(posedge clk) disable iff (reset)
        (mem_read_en && mem_ready) |=> !mem_read_en)
        else $error("mem_read_en stayed high after mem_ready");

endmodule

bind stage_fetch stage_fetch_properties u_fetch_properties (
    .clk              (clk),
    .reset            (reset),
    .pc_out           (pc_out),
    .pc_write_disable (pc_write_disable),
    .d_cache_stall    (d_cache_stall),
    .stall            (stall),
    .mem_read_en      (mem_read_en),
    .mem_ready        (mem_ready),
    .mem_addr         (mem_addr),
    .instruction      (instruction),
    .fetch_exception  (fetch_exception)
);

`default_nettype wire

// File: tests/stage_fetch_tb.sv
`timescale 1ns/1ps
`default_nettype none

module stage_fetch_tb;

    localparam logic [31:0] INIT_ADDR   = 32'h1000;
    localparam int          TLB_ENTRIES = 4;
    localparam logic [2:0]  EXC_OK      = fetch_pkg::EXC_NONE;
    localparam logic [2:0]  EXC_MISS    = fetch_pkg::EXC_ITLB_MISS;

    localparam int OP_FETCH  = 0;
    localparam int OP_MISS   = 1;
    localparam int OP_BRANCH = 2;
    localparam int OP_HOLD   = 3;
    localparam int OP_PRIV   = 4;
    localparam int OP_TRAP   = 5;
    localparam int OP_TLBW   = 6;

    typedef struct {
        int          op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] exp_pc;
        logic [31:0] exp_instr;
        logic [2:0]  exp_exc;
        int          delay;
    } row_t;

    logic                            clk = 1'b0;
    logic                            reset = 1'b1;
    logic                            branch_taken;
    logic [31:0]                     new_pc;
    logic                            pc_write_disable;
    logic                            d_cache_stall;
    logic [fetch_pkg::LINE_BITS-1:0] mem_read_data = '0;
    logic                            mem_ready = 1'b0;
    logic [2:0]                      rob_exception_vector;
    logic [31:0]                     rob_fault_pc;
    logic [31:0]                     rob_fault_addr;
    logic                            priv_write_en;
    logic [2:0]                      priv_idx;
    logic [31:0]                     priv_write_data;
    logic                            itlb_write_en;
    logic [31:0]                     itlb_write_vaddr;
    logic [31:0]                     itlb_write_paddr;
    logic [31:0]                     pc_out;
    logic [31:0]                     instruction;
    logic                            stall;
    logic                            mem_read_en;
    logic [31:0]                     mem_addr;
    logic [2:0]                      fetch_exception;

    row_t        rows [0:63];
    int          row_count = 0;
    int          error_count = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;
    int          expected_requests = 0;
    int          request_count = 0;
    logic [31:0] last_request = '0;
    integer      seed = 17;
    int          mem_delay = 0;
    int          wait_left = 0;
    logic        serving = 1'b0;

    stage_fetch #(
        .INIT_ADDR   (INIT_ADDR),
        .TLB_ENTRIES (TLB_ENTRIES)
    ) DUT (
        .clk                  (clk),
        .reset                (reset),
        .branch_taken         (branch_taken),
        .new_pc               (new_pc),
        .pc_write_disable     (pc_write_disable),
        .d_cache_stall        (d_cache_stall),
        .mem_read_data        (mem_read_data),
        .mem_ready            (mem_ready),
        .rob_exception_vector (rob_exception_vector),
        .rob_fault_pc         (rob_fault_pc),
        .rob_fault_addr       (rob_fault_addr),
        .priv_write_en        (priv_write_en),
        .priv_idx             (priv_idx),
        .priv_write_data      (priv_write_data),
        .itlb_write_en        (itlb_write_en),
        .itlb_write_vaddr     (itlb_write_vaddr),
        .itlb_write_paddr     (itlb_write_paddr),
        .pc_out               (pc_out),
        .instruction          (instruction),
        .stall                (stall),
        .mem_read_en          (mem_read_en),
        .mem_addr             (mem_addr),
        .fetch_exception      (fetch_exception)
    );

    always #4 clk = ~clk;

    // Memory word at a physical address
    function automatic logic [31:0] word_at(input logic [31:0] paddr);
        return {paddr[31:2], 2'b00} ^ 32'hA5A5_0000;
    endfunction

    function automatic logic [fetch_pkg::LINE_BITS-1:0] line_from(input logic [31:0] line_addr);
        fetch_pkg::fetch_addr_u          word_addr;
        logic [fetch_pkg::LINE_BITS-1:0] line;
        word_addr.raw = line_addr;
        for (int k = 0; k < 4; k++) begin
            word_addr.fields.offset = 4'(k * 4);
            line[k*32 +: 32] = word_addr.raw ^ 32'hA5A5_0000;
        end
        return line;
    endfunction

    // Memory answers each request after the row delay plus a random 0 to 3
    always @(negedge clk) begin
        if (reset) begin
            mem_ready = 1'b0;
            serving = 1'b0;
        end else if (mem_ready) begin
            mem_ready = 1'b0;
        end else if (mem_read_en) begin
            if (!serving) begin
                serving = 1'b1;
                wait_left = mem_delay + int'($unsigned($random(seed)) % 4);
            end
            if (wait_left == 0) begin
                mem_read_data = line_from(mem_addr);
                mem_ready = 1'b1;
                serving = 1'b0;
            end else begin
                wait_left--;
            end
        end
    end

    always @(posedge clk) begin
        if (!reset && mem_read_en && mem_ready) begin
            request_count <= request_count + 1;
            last_request  <= mem_addr;
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("CHECKS FAILED");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            error_count++;
            $display("ERR %0t: %s is %h, expected %h", $time, what, actual, expected);
            $display("CHECKS FAILED");
            $fatal(1, "stopping after a failed check");
        end
    endtask

    task automatic add_row(input int op, input logic [31:0] a, input logic [31:0] b,
                           input logic [31:0] exp_pc, input logic [31:0] exp_instr,
                           input logic [2:0] exp_exc, input int delay);
        rows[row_count] = '{op, a, b, exp_pc, exp_instr, exp_exc, delay};
        row_count++;
    endtask

    task automatic drive_idle();
        branch_taken         = 1'b0;
        new_pc               = 32'h0;
        pc_write_disable     = 1'b0;
        d_cache_stall        = 1'b0;
        rob_exception_vector = 3'd0;
        rob_fault_pc         = 32'h0;
        rob_fault_addr       = 32'h0;
        priv_write_en        = 1'b0;
        priv_idx             = 3'd0;
        priv_write_data      = 32'h0;
        itlb_write_en        = 1'b0;
        itlb_write_vaddr     = 32'h0;
        itlb_write_paddr     = 32'h0;
    endtask

    task automatic build_table();
        // Cold start and sequential fetch
        add_row(OP_MISS,  32'h1000, 0, 32'h1000, 32'h0, EXC_OK, 2);
        add_row(OP_FETCH, 0, 0, 32'h1000, word_at(32'h1000), EXC_OK, 0);
        add_row(OP_FETCH, 0, 0, 32'h1004, word_at(32'h1004), EXC_OK, 0);
        add_row(OP_FETCH, 0, 0, 32'h1008, word_at(32'h1008), EXC_OK, 0);
        add_row(OP_FETCH, 0, 0, 32'h100C, word_at(32'h100C), EXC_OK, 0);
        add_row(OP_MISS,  32'h1010, 0, 32'h1010, 32'h0, EXC_OK, 5);
        add_row(OP_FETCH, 0, 0, 32'h1010, word_at(32'h1010), EXC_OK, 0);
        // Branch, then holds that beat a pending branch
        add_row(OP_BRANCH, 32'h1008, 0, 32'h1014, word_at(32'h1014), EXC_OK, 0);
        add_row(OP_FETCH, 0, 0, 32'h1008, word_at(32'h1008), EXC_OK, 0);
        add_row(OP_HOLD,  32'd1, 32'h2000, 32'h100C, word_at(32'h100C), EXC_OK, 0);
        add_row(OP_HOLD,  32'd2, 32'h2000, 32'h100C, word_at(32'h100C), EXC_OK, 0);
        add_row(OP_FETCH, 0, 0, 32'h100C, word_at(32'h100C), EXC_OK, 0);
        add_row(OP_FETCH, 0, 0, 32'h1010, word_at(32'h1010), EXC_OK, 0);
        // Trap to the handler, still supervisor
        add_row(OP_PRIV, 32'(fetch_pkg::PRIV_HANDLER), 32'h3000, 32'h1014,
                word_at(32'h1014), EXC_OK, 0);
        add_row(OP_TRAP, 32'(EXC_MISS), 32'hDEAD_0000, 32'h1018, word_at(32'h1018), EXC_OK, 0);
        add_row(OP_MISS,  32'h3000, 0, 32'h3000, 32'h0, EXC_OK, 0);
        add_row(OP_FETCH, 0, 0, 32'h3000, word_at(32'h3000), EXC_OK, 0);
        // Drop to user mode on an unmapped page
        add_row(OP_PRIV, 32'(fetch_pkg::PRIV_STATUS), 32'h0, 32'h3004,
                word_at(32'h3004), EXC_OK, 0);
        add_row(OP_FETCH, 0, 0, 32'h3008, 32'h0, EXC_MISS, 0);
        add_row(OP_FETCH, 0, 0, 32'h300C, 32'h0, EXC_MISS, 0);
        // Map page 0x3 onto physical page 0x5
        add_row(OP_TLBW,  32'h3000, 32'h5000, 32'h3010, 32'h0, EXC_MISS, 0);
        add_row(OP_MISS,  32'h5010, 0, 32'h3014, 32'h0, EXC_OK, 3);
        add_row(OP_FETCH, 0, 0, 32'h3014, word_at(32'h5014), EXC_OK, 0);
        add_row(OP_FETCH, 0, 0, 32'h3018, word_at(32'h5018), EXC_OK, 0);
        add_row(OP_BRANCH, 32'h8000, 0, 32'h301C, word_at(32'h501C), EXC_OK, 0);
        // Four new pages push the oldest entry out
        add_row(OP_TLBW, 32'h1_0000, 32'h6000, 32'h8000, 32'h0, EXC_MISS, 0);
        add_row(OP_TLBW, 32'h2_0000, 32'h7000, 32'h8004, 32'h0, EXC_MISS, 0);
        add_row(OP_TLBW, 32'h4_0000, 32'h9000, 32'h8008, 32'h0, EXC_MISS, 0);
        add_row(OP_TLBW, 32'h5_0000, 32'hA000, 32'h800C, 32'h0, EXC_MISS, 0);
        add_row(OP_BRANCH, 32'h3018, 0, 32'h8010, 32'h0, EXC_MISS, 0);
        add_row(OP_FETCH, 0, 0, 32'h3018, 32'h0, EXC_MISS, 0);
        add_row(OP_BRANCH, 32'h2_0004, 0, 32'h301C, 32'h0, EXC_MISS, 0);
        add_row(OP_MISS,  32'h7000, 0, 32'h2_0004, 32'h0, EXC_OK, 2);
        add_row(OP_FETCH, 0, 0, 32'h2_0004, word_at(32'h7004), EXC_OK, 0);
        add_row(OP_FETCH, 0, 0, 32'h2_0008, word_at(32'h7008), EXC_OK, 0);
    endtask

    initial begin
        drive_idle();
        reset = 1'b1;
        build_table();
        // Reset, one cycle per row, and a miss costs its delay plus slack
        cycle_limit = 10;
        for (int i = 0; i < row_count; i++) begin
            cycle_limit += (rows[i].op == OP_MISS) ? rows[i].delay + 7 : 1;
        end
        cycle_limit = 2 * cycle_limit + 20;

        repeat (10) @(negedge clk);
        reset = 1'b0;

        for (int i = 0; i < row_count; i++) begin
            drive_idle();
            check_equal(pc_out, rows[i].exp_pc, "pc_out");
            check_equal(instruction, rows[i].exp_instr, "instruction");
            check_equal(32'(fetch_exception), 32'(rows[i].exp_exc), "fetch_exception");
            check_equal(32'(request_count), 32'(expected_requests), "request count");
            if (rows[i].op == OP_MISS) begin
                check_equal(32'(stall), 32'd1, "stall on miss");
                check_equal(32'(mem_read_en), 32'd0, "mem_read_en at detection");
                mem_delay = rows[i].delay;
                @(negedge clk);
                check_equal(32'(mem_read_en), 32'd1, "mem_read_en after detection");
                check_equal(mem_addr, rows[i].a, "mem_addr");
                while (stall) begin
                    @(negedge clk);
                end
                expected_requests++;
                check_equal(32'(request_count), 32'(expected_requests), "request count");
                check_equal(last_request, rows[i].a, "line address answered");
            end else begin
                check_equal(32'(stall), 32'd0, "stall");
                check_equal(32'(mem_read_en), 32'd0, "mem_read_en");
                case (rows[i].op)
                    OP_BRANCH: begin
                        branch_taken = 1'b1;
                        new_pc = rows[i].a;
                    end
                    OP_HOLD: begin
                        pc_write_disable = rows[i].a[0];
                        d_cache_stall = rows[i].a[1];
                        branch_taken = 1'b1;
                        new_pc = rows[i].b;
                    end
                    OP_PRIV: begin
                        priv_write_en = 1'b1;
                        priv_idx = rows[i].a[2:0];
                        priv_write_data = rows[i].b;
                    end
                    OP_TRAP: begin
                        rob_exception_vector = rows[i].a[2:0];
                        rob_fault_pc = pc_out;
                        rob_fault_addr = rows[i].b;
                    end
                    OP_TLBW: begin
                        itlb_write_en = 1'b1;
                        itlb_write_vaddr = rows[i].a;
                        itlb_write_paddr = rows[i].b;
                    end
                    default: begin
                    end
                endcase
                @(negedge clk);
            end
        end

        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("CHECKS FAILED");
            $fatal(1, "run ended with failed checks");
        end
    end

endmodule

`default_nettype wire
